//--- design/adapter_pkg.sv
/*
  adapter_pkg
  configuration map and stream-side types of the fsb to axi4 adapter
*/
package adapter_pkg;

  // config bus fields
  typedef logic [7:0]  cfg_addr_t;
  typedef logic [31:0] cfg_data_t;

  // register map
  localparam cfg_addr_t reg_cfg     = 8'h00;  // bit 4 wvalid mask
  localparam cfg_addr_t reg_cntl    = 8'h08;  // wr bit 0 go/stop, rd status
  localparam cfg_addr_t reg_reset   = 8'h0c;  // bit 0 write reset
  localparam cfg_addr_t reg_base_lo = 8'h20;
  localparam cfg_addr_t reg_base_hi = 8'h24;
  localparam cfg_addr_t reg_head    = 8'h28;  // host read head
  localparam cfg_addr_t reg_size    = 8'h30;  // ring size in bytes

  localparam cfg_data_t cfg_unmapped = 32'hffff_ffff;

  // byte offset inside the ring
  typedef logic [31:0] offset_t;

  // one front-side-bus word
  typedef logic [79:0] fsb_word_t;

  // command pulses, one cycle each
  typedef struct packed {
    logic go;
    logic stop;
    logic wr_reset;
  } cfg_cmd_s;

  // ring setup held in the register block
  typedef struct packed {
    logic [63:0] base;
    offset_t     head;
    offset_t     size;
  } ring_cfg_s;

endpackage

//--- design/axi_pkg.sv
/*
  axi_pkg
  axi4 write-channel widths, line constants and channel structs
*/
package axi_pkg;

  typedef logic [63:0]  axi_addr_t;
  typedef logic [511:0] axi_data_t;
  typedef logic [63:0]  axi_strb_t;
  typedef logic [5:0]   axi_id_t;

  // one line is one 64-byte beat
  localparam int line_bytes = 64;
  localparam logic [2:0] axi_size_line = 3'd6;

  // tail write touches the low 8 bytes only
  localparam axi_strb_t tail_strb = 64'h0000_0000_0000_00ff;

  // each stream word gets its own slot in the line
  localparam int slot_width = 128;

  // write address channel, master side
  typedef struct packed {
    axi_id_t    id;
    axi_addr_t  addr;
    logic [7:0] len;
    logic [2:0] size;
    logic       valid;
  } aw_chan_s;

  // write data channel, master side
  typedef struct packed {
    axi_data_t data;
    axi_strb_t strb;
    logic      last;
    logic      valid;
  } w_chan_s;

  // write response channel, slave side
  typedef struct packed {
    logic [1:0] resp;
    logic       valid;
  } b_chan_s;

endpackage

//--- design/cfg_regs.sv
/*
  cfg_regs
  configuration bus slave: latches each strobe, acknowledges two cycles
  later, holds the ring setup and mask, and turns CNTL and RESET writes
  into command pulses for the write controller
*/
`timescale 1ns/1ps

module cfg_regs (
  input  logic                   clk,
  input  logic                   sync_rst_n,
  input  logic                   cfg_wr_i,
  input  logic                   cfg_rd_i,
  input  adapter_pkg::cfg_addr_t cfg_addr_i,
  input  adapter_pkg::cfg_data_t cfg_wdata_i,
  output logic                   cfg_ack_o,
  output adapter_pkg::cfg_data_t cfg_rdata_o,
  input  logic                   wr_inp_i,
  input  logic                   stop_pend_i,
  input  logic                   bresp_err_i,
  output adapter_pkg::cfg_cmd_s  cmd_o,
  output adapter_pkg::ring_cfg_s ring_o,
  output logic                   wvalid_mask_o
);

  logic                   wr_pend_q;
  logic                   rd_pend_q;
  logic                   ack_q;
  adapter_pkg::cfg_addr_t addr_q;
  adapter_pkg::cfg_data_t wdata_q;
  adapter_pkg::cfg_data_t rdata_q;
  logic                   mask_q;
  logic [63:0]            base_q;
  adapter_pkg::offset_t   head_q;
  adapter_pkg::offset_t   size_q;
  logic                   commit;
  logic                   wr_at_ack;

  // -------------------------------------------------
  // request stretch and ack
  // -------------------------------------------------
  // edge before the ack, registers and readback land here
  assign commit    = (wr_pend_q || rd_pend_q) && !ack_q;
  assign wr_at_ack = wr_pend_q && ack_q;

  always_ff @(posedge clk)
  begin
    if (!sync_rst_n)
    begin
      wr_pend_q <= 1'b0;
      rd_pend_q <= 1'b0;
      ack_q     <= 1'b0;
    end
    else
    begin
      wr_pend_q <= cfg_wr_i || (wr_pend_q && !ack_q);
      rd_pend_q <= cfg_rd_i || (rd_pend_q && !ack_q);
      ack_q     <= commit;
    end
  end

  // address and data of the strobe
  always_ff @(posedge clk)
  begin
    if (cfg_wr_i || cfg_rd_i)
    begin
      addr_q  <= cfg_addr_i;
      wdata_q <= cfg_wdata_i;
    end
  end

  // -------------------------------------------------
  // register storage
  // -------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (!sync_rst_n)
    begin
      mask_q <= 1'b0;
      base_q <= '0;
      head_q <= '0;
      size_q <= '0;
    end
    else if (commit && wr_pend_q)
    begin
      case (addr_q)
        adapter_pkg::reg_cfg:     mask_q         <= wdata_q[4];
        adapter_pkg::reg_base_lo: base_q[31:0]   <= wdata_q;
        adapter_pkg::reg_base_hi: base_q[63:32]  <= wdata_q;
        adapter_pkg::reg_head:    head_q         <= wdata_q;
        adapter_pkg::reg_size:    size_q         <= wdata_q;
        default:                  mask_q         <= mask_q;
      endcase
    end
  end

  // readback, presented with the ack
  always_ff @(posedge clk)
  begin
    if (commit)
    begin
      case (addr_q)
        adapter_pkg::reg_cfg:     rdata_q <= {27'b0, mask_q, 4'b0};
        adapter_pkg::reg_cntl:    rdata_q <= {29'b0, bresp_err_i, stop_pend_i, wr_inp_i};
        adapter_pkg::reg_base_lo: rdata_q <= base_q[31:0];
        adapter_pkg::reg_base_hi: rdata_q <= base_q[63:32];
        adapter_pkg::reg_head:    rdata_q <= head_q;
        adapter_pkg::reg_size:    rdata_q <= size_q;
        default:                  rdata_q <= adapter_pkg::cfg_unmapped;
      endcase
    end
  end

  // command pulses in the ack cycle
  assign cmd_o.go       = wr_at_ack && (addr_q == adapter_pkg::reg_cntl) && wdata_q[0];
  assign cmd_o.stop     = wr_at_ack && (addr_q == adapter_pkg::reg_cntl) && !wdata_q[0];
  assign cmd_o.wr_reset = wr_at_ack && (addr_q == adapter_pkg::reg_reset) && wdata_q[0];

  assign ring_o        = '{base: base_q, head: head_q, size: size_q};
  assign wvalid_mask_o = mask_q;
  assign cfg_ack_o     = ack_q;
  assign cfg_rdata_o   = rdata_q;

  // host waits for the ack before the next strobe
  a_no_overlap: assert property (@(posedge clk) disable iff (!sync_rst_n)
    commit |-> !(cfg_wr_i || cfg_rd_i));

endmodule

//--- design/wr_ctrl.sv
/*
  wr_ctrl
  write sequencer: one data line, then its tail write, then either
  the next line or a pause when the ring is full or a stop is pending
*/
`timescale 1ns/1ps

module wr_ctrl (
  input  logic                  clk,
  input  logic                  sync_rst_n,
  input  adapter_pkg::cfg_cmd_s cmd_i,
  input  logic                  line_valid_i,
  input  logic                  full_i,
  input  logic                  busy_i,
  input  logic                  done_i,
  output logic                  line_take_o,
  output logic                  issue_data_o,
  output logic                  issue_tail_o,
  output logic                  advance_o,
  output logic                  wr_inp_o,
  output logic                  stop_pend_o
);

  typedef enum logic [1:0] {
    IDLE,
    DATA,
    TAIL,
    STOP
  } state_e;

  state_e state_q;
  state_e state_n;
  logic   stop_pend_q;

  // -------------------------------------------------
  // next state
  // -------------------------------------------------
  always_comb
  begin
    state_n = state_q;
    case (state_q)
      IDLE:
        if (cmd_i.go)
          state_n = DATA;
      // data write outstanding until done
      DATA:
        if (done_i)
          state_n = TAIL;
      // tail done, decide between next line and pause
      TAIL:
        if (done_i)
        begin
          if (full_i || stop_pend_q || cmd_i.stop)
            state_n = STOP;
          else
            state_n = DATA;
        end
      STOP:
        if (cmd_i.wr_reset)
          state_n = IDLE;
        else if (!full_i && !stop_pend_q)
          state_n = DATA;
      default:
        state_n = IDLE;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (!sync_rst_n)
    begin
      state_q     <= IDLE;
      stop_pend_q <= 1'b0;
    end
    else
    begin
      state_q     <= state_n;
      // soft stop holds until the FSM is back in idle
      stop_pend_q <= cmd_i.stop || (stop_pend_q && (state_n != IDLE));
    end
  end

  // -------------------------------------------------
  // issue pulses
  // -------------------------------------------------
  // done cycle has busy low already, so gate on it
  assign issue_data_o = (state_q == DATA) && line_valid_i && !busy_i && !done_i;
  assign issue_tail_o = (state_q == TAIL) && !busy_i && !done_i;

  // line enters the W register with the issue
  assign line_take_o = issue_data_o;
  assign advance_o   = (state_q == DATA) && done_i;

  assign wr_inp_o    = (state_q == DATA) || (state_q == TAIL);
  assign stop_pend_o = stop_pend_q;

  a_one_issue: assert property (@(posedge clk) disable iff (!sync_rst_n)
    !(issue_data_o && issue_tail_o));

endmodule

//--- design/ring_addr_gen.sv
/*
  ring_addr_gen
  ring write offset with wrap, full detection against the host head,
  and the line address, tail address and tail value
*/
`timescale 1ns/1ps

module ring_addr_gen (
  input  logic                   clk,
  input  logic                   sync_rst_n,
  input  adapter_pkg::ring_cfg_s ring_i,
  input  logic                   restart_i,
  input  logic                   advance_i,
  output axi_pkg::axi_addr_t     line_addr_o,
  output axi_pkg::axi_addr_t     tail_addr_o,
  output adapter_pkg::offset_t   tail_value_o,
  output logic                   full_o
);

  adapter_pkg::offset_t off_q;
  adapter_pkg::offset_t off_inc;
  adapter_pkg::offset_t off_next;

  // next offset, modulo ring size
  assign off_inc  = off_q + adapter_pkg::offset_t'(axi_pkg::line_bytes);
  assign off_next = (off_inc == ring_i.size) ? '0 : off_inc;

  always_ff @(posedge clk)
  begin
    if (!sync_rst_n || restart_i)
      off_q <= '0;
    else if (advance_i)
      off_q <= off_next;
  end

  assign line_addr_o  = ring_i.base + axi_pkg::axi_addr_t'(off_q);
  // tail slot sits just past the ring
  assign tail_addr_o  = ring_i.base + axi_pkg::axi_addr_t'(ring_i.size);
  assign tail_value_o = off_q;

  // one more line would catch up with the reader
  assign full_o = (off_next == ring_i.head);

endmodule

//--- design/fsb_packer.sv
/*
  fsb_packer
  gathers four stream words into one 512-bit line, one word per
  128-bit slot, and holds the line until the controller takes it
*/
`timescale 1ns/1ps

module fsb_packer #(
  parameter int fsb_width_p = 80
) (
  input  logic                   clk,
  input  logic                   sync_rst_n,
  input  logic                   fsb_v_i,
  input  adapter_pkg::fsb_word_t fsb_data_i,
  output logic                   fsb_yumi_o,
  input  logic                   wvalid_mask_i,
  input  logic                   line_take_i,
  output logic                   line_valid_o,
  output axi_pkg::axi_data_t     line_o
);

  logic [1:0]                     cnt_q;
  logic                           full_q;
  axi_pkg::axi_data_t             line_q;
  logic [axi_pkg::slot_width-1:0] slot_d;
  logic                           take;

  // take a word only while collecting
  assign take       = fsb_v_i && wvalid_mask_i && !full_q;
  assign fsb_yumi_o = take;

  // zero-extend into the slot
  always_comb
  begin
    slot_d = '0;
    slot_d[fsb_width_p-1:0] = fsb_data_i[fsb_width_p-1:0];
  end

  always_ff @(posedge clk)
  begin
    if (!sync_rst_n)
    begin
      cnt_q  <= 2'd0;
      full_q <= 1'b0;
    end
    else
    begin
      if (take)
        cnt_q <= cnt_q + 2'd1;
      // fourth word closes the line
      if (take && (cnt_q == 2'd3))
        full_q <= 1'b1;
      else if (line_take_i)
        full_q <= 1'b0;
    end
  end

  // word k lands in slot k
  always_ff @(posedge clk)
  begin
    if (take)
      line_q[cnt_q * axi_pkg::slot_width +: axi_pkg::slot_width] <= slot_d;
  end

  assign line_valid_o = full_q;
  assign line_o       = line_q;

endmodule

//--- design/axi_wr_master.sv
/*
  axi_wr_master
  single-beat axi4 writes: loads AW and W for a data line or a tail
  write, holds each valid until its ready, reports done on B
*/
`timescale 1ns/1ps

module axi_wr_master (
  input  logic                 clk,
  input  logic                 sync_rst_n,
  input  logic                 issue_data_i,
  input  logic                 issue_tail_i,
  input  axi_pkg::axi_data_t   line_i,
  input  axi_pkg::axi_addr_t   line_addr_i,
  input  axi_pkg::axi_addr_t   tail_addr_i,
  input  adapter_pkg::offset_t tail_value_i,
  output axi_pkg::aw_chan_s    aw_o,
  input  logic                 awready_i,
  output axi_pkg::w_chan_s     w_o,
  input  logic                 wready_i,
  input  axi_pkg::b_chan_s     b_i,
  output logic                 bready_o,
  output logic                 busy_o,
  output logic                 done_o,
  output logic                 bresp_err_o
);

  localparam int pad_w = $bits(axi_pkg::axi_data_t) - $bits(adapter_pkg::offset_t);

  logic               aw_v_q;
  logic               w_v_q;
  logic               busy_q;
  logic               done_q;
  logic               err_q;
  axi_pkg::axi_addr_t addr_q;
  axi_pkg::axi_data_t data_q;
  axi_pkg::axi_strb_t strb_q;
  logic               issue;

  assign issue = issue_data_i || issue_tail_i;

  // -------------------------------------------------
  // beat payload
  // -------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (issue_data_i)
    begin
      addr_q <= line_addr_i;
      data_q <= line_i;
      strb_q <= '1;
    end
    else if (issue_tail_i)
    begin
      // offset in the low word, rest ones
      addr_q <= tail_addr_i;
      data_q <= {{pad_w{1'b1}}, tail_value_i};
      strb_q <= axi_pkg::tail_strb;
    end
  end

  // valids, outstanding flag, response
  always_ff @(posedge clk)
  begin
    if (!sync_rst_n)
    begin
      aw_v_q <= 1'b0;
      w_v_q  <= 1'b0;
      busy_q <= 1'b0;
      done_q <= 1'b0;
      err_q  <= 1'b0;
    end
    else
    begin
      if (issue)
        aw_v_q <= 1'b1;
      else if (awready_i)
        aw_v_q <= 1'b0;
      if (issue)
        w_v_q <= 1'b1;
      else if (wready_i)
        w_v_q <= 1'b0;
      if (issue)
        busy_q <= 1'b1;
      else if (b_i.valid)
        busy_q <= 1'b0;
      done_q <= b_i.valid;
      // SLVERR or DECERR
      if (b_i.valid)
        err_q <= b_i.resp[1];
    end
  end

  assign aw_o = '{id: '0, addr: addr_q, len: 8'd0,
                  size: axi_pkg::axi_size_line, valid: aw_v_q};
  assign w_o  = '{data: data_q, strb: strb_q, last: 1'b1, valid: w_v_q};

  assign bready_o    = 1'b1;
  assign busy_o      = busy_q;
  assign done_o      = done_q;
  assign bresp_err_o = err_q;

  a_aw_stable: assert property (@(posedge clk) disable iff (!sync_rst_n)
    aw_o.valid && !awready_i |=> $stable(aw_o));

endmodule

//--- design/fsb_axi_top.sv
/*
  fsb_axi_top
  fsb stream to axi4 ring buffer adapter: register block, packer,
  write sequencer, ring address generator and write master
*/
`timescale 1ns/1ps

module fsb_axi_top #(
  parameter int fsb_width_p = 80
) (
  input  logic                   clk,
  input  logic                   sync_rst_n,
  input  logic                   cfg_wr_i,
  input  logic                   cfg_rd_i,
  input  adapter_pkg::cfg_addr_t cfg_addr_i,
  input  adapter_pkg::cfg_data_t cfg_wdata_i,
  output logic                   cfg_ack_o,
  output adapter_pkg::cfg_data_t cfg_rdata_o,
  input  logic                   fsb_v_i,
  input  adapter_pkg::fsb_word_t fsb_data_i,
  output logic                   fsb_yumi_o,
  output axi_pkg::aw_chan_s      aw_o,
  input  logic                   awready_i,
  output axi_pkg::w_chan_s       w_o,
  input  logic                   wready_i,
  input  axi_pkg::b_chan_s       b_i,
  output logic                   bready_o
);

  adapter_pkg::cfg_cmd_s  cmd;
  adapter_pkg::ring_cfg_s ring;
  logic                   wvalid_mask;
  logic                   wr_inp;
  logic                   stop_pend;
  logic                   bresp_err;
  // packer to write path
  logic                   line_valid;
  logic                   line_take;
  axi_pkg::axi_data_t     line;
  // sequencer to master and address gen
  logic                   issue_data;
  logic                   issue_tail;
  logic                   advance;
  logic                   busy;
  logic                   done;
  logic                   full;
  axi_pkg::axi_addr_t     line_addr;
  axi_pkg::axi_addr_t     tail_addr;
  adapter_pkg::offset_t   tail_value;

  cfg_regs cfg_regs_inst (
    .clk, .sync_rst_n, .cfg_wr_i, .cfg_rd_i, .cfg_addr_i, .cfg_wdata_i,
    .cfg_ack_o, .cfg_rdata_o,
    .wr_inp_i(wr_inp), .stop_pend_i(stop_pend), .bresp_err_i(bresp_err),
    .cmd_o(cmd), .ring_o(ring), .wvalid_mask_o(wvalid_mask)
  );

  fsb_packer #(.fsb_width_p(fsb_width_p)) fsb_packer_inst (
    .clk, .sync_rst_n, .fsb_v_i, .fsb_data_i, .fsb_yumi_o,
    .wvalid_mask_i(wvalid_mask), .line_take_i(line_take),
    .line_valid_o(line_valid), .line_o(line)
  );

  wr_ctrl wr_ctrl_inst (
    .clk, .sync_rst_n, .cmd_i(cmd), .line_valid_i(line_valid),
    .full_i(full), .busy_i(busy), .done_i(done),
    .line_take_o(line_take), .issue_data_o(issue_data), .issue_tail_o(issue_tail),
    .advance_o(advance), .wr_inp_o(wr_inp), .stop_pend_o(stop_pend)
  );

  // write reset rewinds the ring to offset 0
  ring_addr_gen ring_addr_gen_inst (
    .clk, .sync_rst_n, .ring_i(ring), .restart_i(cmd.wr_reset),
    .advance_i(advance), .line_addr_o(line_addr), .tail_addr_o(tail_addr),
    .tail_value_o(tail_value), .full_o(full)
  );

  axi_wr_master axi_wr_master_inst (
    .clk, .sync_rst_n, .issue_data_i(issue_data), .issue_tail_i(issue_tail),
    .line_i(line), .line_addr_i(line_addr), .tail_addr_i(tail_addr),
    .tail_value_i(tail_value), .aw_o, .awready_i, .w_o, .wready_i, .b_i,
    .bready_o, .busy_o(busy), .done_o(done), .bresp_err_o(bresp_err)
  );

endmodule

//--- testbench/tb_fsb_axi_tasks.svh
/*
  directed tests of the fsb to axi4 adapter, with config bus access,
  stream driver, expected-beat builders and typed compare tasks
*/

adapter_pkg::fsb_word_t words[4];

task automatic check_cfg(input string name, input adapter_pkg::cfg_data_t got,
                         input adapter_pkg::cfg_data_t exp);
  checks++;
  if (got !== exp)
  begin
    $display("error %s: got %h expected %h", name, got, exp);
    errors++;
  end
endtask

task automatic check_addr(input string name, input axi_pkg::axi_addr_t got,
                          input axi_pkg::axi_addr_t exp);
  checks++;
  if (got !== exp)
  begin
    $display("error %s: got %h expected %h", name, got, exp);
    errors++;
  end
endtask

task automatic check_data(input string name, input axi_pkg::axi_data_t got,
                          input axi_pkg::axi_data_t exp, input axi_pkg::axi_strb_t got_s,
                          input axi_pkg::axi_strb_t exp_s);
  checks++;
  if (got !== exp || got_s !== exp_s)
  begin
    $display("error %s: got %h strb %h expected %h strb %h", name, got, got_s, exp, exp_s);
    errors++;
  end
endtask

// every write is one beat of 64 bytes
task automatic check_burst(input string name, input axi_pkg::aw_chan_s aw,
                           input logic last);
  checks++;
  if (aw.len !== 8'd0 || aw.size !== 3'd6 || last !== 1'b1)
  begin
    $display("error %s: got awlen %h awsize %h wlast %h expected 00 6 1",
             name, aw.len, aw.size, last);
    errors++;
  end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
  checks++;
  if (got !== exp)
  begin
    $display("error %s: got %h expected %h", name, got, exp);
    errors++;
  end
endtask

task automatic reset_dut();
  q_addr.delete();
  q_data.delete();
  q_strb.delete();
  err_idx = -1;
  @(posedge clk);
  sync_rst_n <= 1'b0;
  repeat (3) @(posedge clk);
  sync_rst_n <= 1'b1;
endtask

// one strobe, ack expected exactly 2 cycles later
task automatic cfg_access(input logic wr, input adapter_pkg::cfg_addr_t a,
                          input adapter_pkg::cfg_data_t d,
                          output adapter_pkg::cfg_data_t rd);
  int n;
  @(posedge clk);
  cfg_wr_i    <= wr;
  cfg_rd_i    <= !wr;
  cfg_addr_i  <= a;
  cfg_wdata_i <= d;
  @(posedge clk);
  cfg_wr_i <= 1'b0;
  cfg_rd_i <= 1'b0;
  n = 0;
  do
  begin
    @(negedge clk);
    n++;
  end
  while (!cfg_ack_o && n < 10);
  if (n != 2)
  begin
    $display("config ack for address %h came after %0d cycles instead of 2", a, n);
    errors++;
  end
  rd = cfg_rdata_o;
endtask

task automatic cfg_write(input adapter_pkg::cfg_addr_t a, input adapter_pkg::cfg_data_t d);
  adapter_pkg::cfg_data_t unused;
  cfg_access(1'b1, a, d, unused);
endtask

task automatic setup_ring(input axi_pkg::axi_addr_t base, input adapter_pkg::offset_t head,
                          input adapter_pkg::offset_t size);
  cfg_write(adapter_pkg::reg_base_lo, base[31:0]);
  cfg_write(adapter_pkg::reg_base_hi, base[63:32]);
  cfg_write(adapter_pkg::reg_head, head);
  cfg_write(adapter_pkg::reg_size, size);
  // mask on, then go
  cfg_write(adapter_pkg::reg_cfg, 32'h10);
  cfg_write(adapter_pkg::reg_cntl, 32'h1);
endtask

// fresh random words, then each one held until yumi
task automatic send_line();
  for (int k = 0; k < 4; k++)
  begin
    stim_q = xorshift(stim_q);
    words[k][79:64] = stim_q[15:0];
    stim_q = xorshift(stim_q);
    words[k][63:32] = stim_q;
    stim_q = xorshift(stim_q);
    words[k][31:0] = stim_q;
  end
  @(posedge clk);
  for (int k = 0; k < 4; k++)
  begin
    fsb_v_i    <= 1'b1;
    fsb_data_i <= words[k];
    do
      @(negedge clk);
    while (!fsb_yumi_o);
    @(posedge clk);
  end
  fsb_v_i <= 1'b0;
endtask

// each word zero-extended into its 128-bit slot
function automatic axi_pkg::axi_data_t line_beat();
  axi_pkg::axi_data_t d;
  d = '0;
  for (int k = 0; k < 4; k++)
    d[k*128 +: 128] = {48'b0, words[k]};
  return d;
endfunction

function automatic axi_pkg::axi_data_t tail_beat(input adapter_pkg::offset_t v);
  return {{480{1'b1}}, v};
endfunction

task automatic expect_write(input string what, input axi_pkg::axi_addr_t a,
                            input axi_pkg::axi_data_t d, input axi_pkg::axi_strb_t s);
  int n;
  n = 0;
  while (q_addr.size() == 0 && n < 1000)
  begin
    @(negedge clk);
    n++;
  end
  if (q_addr.size() == 0)
  begin
    $display("no AXI write arrived for the %s", what);
    errors++;
  end
  else
  begin
    check_addr({what, " awaddr"}, q_addr.pop_front(), a);
    check_data({what, " wdata"}, q_data.pop_front(), d, q_strb.pop_front(), s);
  end
endtask

// stream offered for a while, must not be taken
task automatic hold_stream_idle(input string why);
  @(posedge clk);
  fsb_v_i <= 1'b1;
  repeat (20)
  begin
    @(negedge clk);
    if (fsb_yumi_o || aw_o.valid)
    begin
      $display("stream taken or AXI write issued while %s", why);
      errors++;
    end
  end
  @(posedge clk);
  fsb_v_i <= 1'b0;
endtask

// poll CNTL status until the given bits match
task automatic poll_status(input adapter_pkg::cfg_data_t bits, input adapter_pkg::cfg_data_t exp);
  adapter_pkg::cfg_data_t rd;
  int n;
  n = 0;
  do
  begin
    cfg_access(1'b0, adapter_pkg::reg_cntl, '0, rd);
    n++;
  end
  while ((rd & bits) != exp && n < 30);
  check_cfg("cntl status", rd & bits, exp);
endtask

task automatic report(input string name, input int err_before);
  $display("test %s: %s", name, (errors == err_before) ? "ok" : "failed");
endtask

// --------------------------------------------------
// directed tests
// --------------------------------------------------
task automatic test_regs();
  adapter_pkg::cfg_data_t rd;
  int e;
  e = errors;
  reset_dut();
  cfg_write(adapter_pkg::reg_base_lo, 32'h1000_0000);
  cfg_write(adapter_pkg::reg_base_hi, 32'h0000_0002);
  cfg_write(adapter_pkg::reg_head, 32'h0000_0040);
  cfg_write(adapter_pkg::reg_size, 32'h0000_2000);
  cfg_access(1'b0, adapter_pkg::reg_base_lo, '0, rd);
  check_cfg("base_lo", rd, 32'h1000_0000);
  cfg_access(1'b0, adapter_pkg::reg_base_hi, '0, rd);
  check_cfg("base_hi", rd, 32'h0000_0002);
  cfg_access(1'b0, adapter_pkg::reg_head, '0, rd);
  check_cfg("head", rd, 32'h0000_0040);
  cfg_access(1'b0, adapter_pkg::reg_size, '0, rd);
  check_cfg("size", rd, 32'h0000_2000);
  cfg_access(1'b0, 8'h10, '0, rd);
  check_cfg("unmapped 0x10", rd, 32'hffff_ffff);
  report("register access", e);
endtask

task automatic test_one_line();
  int e;
  e = errors;
  reset_dut();
  setup_ring(64'h2_1000_0000, 32'h0, 32'h1000);
  send_line();
  expect_write("data line", 64'h2_1000_0000, line_beat(), '1);
  expect_write("tail", 64'h2_1000_1000, tail_beat(64), axi_pkg::tail_strb);
  report("one line", e);
endtask

task automatic test_wrap();
  int e;
  e = errors;
  reset_dut();
  setup_ring(64'h4000, 32'h1000, 32'd256);
  for (int i = 0; i < 5; i++)
  begin
    send_line();
    expect_write("data line", 64'h4000 + (i * 64) % 256, line_beat(), '1);
    expect_write("tail", 64'h4100, tail_beat(((i + 1) * 64) % 256), axi_pkg::tail_strb);
  end
  report("wrap", e);
endtask

task automatic test_full_pause();
  int e;
  e = errors;
  reset_dut();
  setup_ring(64'h8000, 32'd192, 32'd256);
  send_line();
  expect_write("data line", 64'h8000, line_beat(), '1);
  expect_write("tail", 64'h8100, tail_beat(64), axi_pkg::tail_strb);
  send_line();
  expect_write("data line", 64'h8040, line_beat(), '1);
  expect_write("tail", 64'h8100, tail_beat(128), axi_pkg::tail_strb);
  // packer still fills one line, then stalls
  send_line();
  hold_stream_idle("the ring is full");
  cfg_write(adapter_pkg::reg_head, 32'h0);
  expect_write("resumed data line", 64'h8080, line_beat(), '1);
  expect_write("tail", 64'h8100, tail_beat(192), axi_pkg::tail_strb);
  report("full pause", e);
endtask

task automatic test_stop_reset_mask();
  int e;
  e = errors;
  reset_dut();
  setup_ring(64'hc000, 32'h0, 32'h1000);
  cfg_write(adapter_pkg::reg_cntl, 32'h0);
  send_line();
  expect_write("data line", 64'hc000, line_beat(), '1);
  expect_write("tail", 64'hd000, tail_beat(64), axi_pkg::tail_strb);
  poll_status(32'h3, 32'h2);
  cfg_write(adapter_pkg::reg_reset, 32'h1);
  poll_status(32'h3, 32'h0);
  cfg_write(adapter_pkg::reg_cfg, 32'h0);
  hold_stream_idle("the wvalid mask is clear");
  report("stop, reset and mask", e);
endtask

task automatic test_resp_error();
  int e;
  e = errors;
  reset_dut();
  // second write after reset is the tail
  err_idx = 1;
  setup_ring(64'h1_0000, 32'h0, 32'h1000);
  send_line();
  expect_write("data line", 64'h1_0000, line_beat(), '1);
  expect_write("tail", 64'h1_1000, tail_beat(64), axi_pkg::tail_strb);
  poll_status(32'h4, 32'h4);
  report("response error", e);
endtask

//--- testbench/tb_fsb_axi.sv
/*
  tb_fsb_axi
  testbench for the fsb to axi4 ring adapter: clock, reset, DUT,
  watchdog, single-outstanding AXI write slave and the test sequence
*/
`timescale 1ns/1ps

module tb_fsb_axi;

  // six tests, generous cycle budget each
  localparam int test_budget = 3000;
  localparam int run_cycles  = 6 * test_budget;

  logic                   clk;
  logic                   sync_rst_n;
  logic                   cfg_wr_i;
  logic                   cfg_rd_i;
  adapter_pkg::cfg_addr_t cfg_addr_i;
  adapter_pkg::cfg_data_t cfg_wdata_i;
  logic                   cfg_ack_o;
  adapter_pkg::cfg_data_t cfg_rdata_o;
  logic                   fsb_v_i;
  adapter_pkg::fsb_word_t fsb_data_i;
  logic                   fsb_yumi_o;
  axi_pkg::aw_chan_s      aw_o;
  logic                   awready_i;
  axi_pkg::w_chan_s       w_o;
  logic                   wready_i;
  axi_pkg::b_chan_s       b_i;
  logic                   bready_o;

  // slave model state
  axi_pkg::axi_addr_t q_addr[$];
  axi_pkg::axi_data_t q_data[$];
  axi_pkg::axi_strb_t q_strb[$];
  axi_pkg::aw_chan_s  aw_s;
  axi_pkg::axi_data_t w_data_s;
  axi_pkg::axi_strb_t w_strb_s;
  logic               w_last_s;
  logic               got_aw;
  logic               got_w;
  logic               b_pend;
  logic [1:0]         b_wait;
  int                 wr_count;
  int                 err_idx;
  logic [31:0]        rnd_q;
  logic [31:0]        stim_q;
  int                 errors;
  int                 checks;

  fsb_axi_top #(.fsb_width_p(80)) fsb_axi_top_inst (
    .clk, .sync_rst_n, .cfg_wr_i, .cfg_rd_i, .cfg_addr_i, .cfg_wdata_i,
    .cfg_ack_o, .cfg_rdata_o, .fsb_v_i, .fsb_data_i, .fsb_yumi_o,
    .aw_o, .awready_i, .w_o, .wready_i, .b_i, .bready_o
  );

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  `include "tb_fsb_axi_tasks.svh"

  initial
  begin
    clk = 1'b0;
  end

  always #5 clk = ~clk;

  // --------------------------------------------------
  // AXI write slave
  // --------------------------------------------------
  // random ready, one write in flight, B after a short random delay
  always @(posedge clk)
  begin
    logic aw_done;
    logic w_done;
    aw_done = got_aw || (aw_o.valid && awready_i);
    w_done  = got_w || (w_o.valid && wready_i);
    if (!sync_rst_n)
    begin
      awready_i <= 1'b0;
      wready_i  <= 1'b0;
      b_i       <= '0;
      got_aw    <= 1'b0;
      got_w     <= 1'b0;
      b_pend    <= 1'b0;
      b_wait    <= 2'd0;
      wr_count  <= 0;
    end
    else
    begin
      rnd_q     = xorshift(rnd_q);
      awready_i <= rnd_q[0] | rnd_q[1];
      wready_i  <= rnd_q[2] | rnd_q[3];
      b_i       <= '0;
      if (aw_o.valid && awready_i)
      begin
        aw_s   <= aw_o;
        got_aw <= 1'b1;
      end
      if (w_o.valid && wready_i)
      begin
        w_data_s <= w_o.data;
        w_strb_s <= w_o.strb;
        w_last_s <= w_o.last;
        got_w    <= 1'b1;
      end
      if (aw_done && w_done && !b_pend)
      begin
        check_burst("write", got_aw ? aw_s : aw_o, got_w ? w_last_s : w_o.last);
        q_addr.push_back(got_aw ? aw_s.addr : aw_o.addr);
        q_data.push_back(got_w ? w_data_s : w_o.data);
        q_strb.push_back(got_w ? w_strb_s : w_o.strb);
        got_aw <= 1'b0;
        got_w  <= 1'b0;
        b_pend <= 1'b1;
        b_wait <= rnd_q[5:4];
      end
      else if (b_pend)
      begin
        if (b_wait == 2'd0)
        begin
          // master must accept B at any time
          check_bit("bready", bready_o, 1'b1);
          // SLVERR only on the armed write
          b_i      <= '{resp: (wr_count == err_idx) ? 2'b10 : 2'b00, valid: 1'b1};
          b_pend   <= 1'b0;
          wr_count <= wr_count + 1;
        end
        else
          b_wait <= b_wait - 2'd1;
      end
    end
  end

  // watchdog
  initial
  begin
    #(run_cycles * 10);
    $display("watchdog: run did not finish within %0d cycles", run_cycles);
    $display("TB FAILED");
    $finish;
  end

  // --------------------------------------------------
  // test sequence
  // --------------------------------------------------
  initial
  begin
    sync_rst_n  = 1'b0;
    cfg_wr_i    = 1'b0;
    cfg_rd_i    = 1'b0;
    cfg_addr_i  = '0;
    cfg_wdata_i = '0;
    fsb_v_i     = 1'b0;
    fsb_data_i  = '0;
    awready_i   = 1'b0;
    wready_i    = 1'b0;
    b_i         = '0;
    rnd_q       = 32'hcbb1_28b0;
    stim_q      = 32'hcbb1_28b0;
    errors      = 0;
    checks      = 0;
    err_idx     = -1;
    test_regs();
    test_one_line();
    test_wrap();
    test_full_pause();
    test_stop_reset_mask();
    test_resp_error();
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0)
      $display("TB PASSED");
    else
      $display("TB FAILED");
    $finish;
  end

endmodule

//--- project.f
+incdir+testbench
design/adapter_pkg.sv
design/axi_pkg.sv
design/cfg_regs.sv
design/wr_ctrl.sv
design/ring_addr_gen.sv
design/fsb_packer.sv
design/axi_wr_master.sv
design/fsb_axi_top.sv
testbench/tb_fsb_axi.sv

//--- Makefile
# Verilator flow for the fsb to axi4 adapter testbench

TOP := tb_fsb_axi

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f project.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f project.f -o $(TOP)_sim
	./obj_dir/$(TOP)_sim | tee /dev/stderr | grep -q "TB PASSED"

clean:
	rm -rf obj_dir
